//--- src/obj_pkg.sv
/*
 * sprite engine shared definitions
 * table entry layout, attribute bit positions and field widths
 */
package obj_pkg;

    // sprite geometry
    localparam int OBJ_SIZE    = 16;
    localparam int ROW_W       = $clog2(OBJ_SIZE);

    // table entry, four 16-bit words per sprite
    localparam int ENTRY_WORDS = 4;
    localparam int WORD_W      = 16;
    localparam int W_X         = 0;
    localparam int W_Y         = 1;
    localparam int W_CODE      = 2;
    localparam int W_ATTR      = 3;

    // attribute word
    localparam int ATTR_PAL_LSB  = 0;    // bits 4:0
    localparam int ATTR_HFLIP    = 5;
    localparam int ATTR_VFLIP    = 6;
    localparam int ATTR_PRIO_LSB = 7;    // bits 9:7
    localparam int ATTR_HIDE     = 15;

    localparam int PAL_W   = 5;
    localparam int PRIO_W  = 3;
    localparam int COLOR_W = 4;          // 4bpp graphics

    // screen coordinates and line buffer entries
    localparam int POS_W = 9;
    localparam int PXL_W = PRIO_W + PAL_W + COLOR_W;   // {prio, pal, color}

    // scroll offset registers
    localparam int CFG_OFF_X = 0;
    localparam int CFG_OFF_Y = 1;

endpackage

//--- src/obj_if.sv
/*
 * sprite engine internal links
 * table read port from the scanner and the scanner to drawer handshake
 */
`timescale 1ns/1ps

interface obj_table_if import obj_pkg::*; #(parameter int AW = 4) ();
    logic [AW-1:0]     addr;     // entry index
    logic [WORD_W-1:0] x;
    logic [WORD_W-1:0] y;
    logic [WORD_W-1:0] code;
    logic [WORD_W-1:0] attr;

    modport scan (output addr, input x, y, code, attr);
    modport ram  (input addr, output x, y, code, attr);
endinterface

interface obj_draw_if import obj_pkg::*; ();
    logic              start;    // one cycle strobe, fields valid with it
    logic              idle;
    logic [WORD_W-1:0] code;
    logic [POS_W-1:0]  hpos;
    logic [ROW_W-1:0]  row;      // vflip already applied
    logic              hflip;
    logic [PAL_W-1:0]  pal;
    logic [PRIO_W-1:0] prio;

    modport scan (output start, code, hpos, row, hflip, pal, prio, input idle);
    modport draw (input start, code, hpos, row, hflip, pal, prio, output idle);
endinterface

//--- src/obj_frame_copy.sv
/*
 * sprite table copier
 * reads the whole table from object RAM once per frame,
 * starting when vertical blanking begins
 */
`timescale 1ns/1ps

module obj_frame_copy import obj_pkg::*; #(
    parameter int  OBJ_COUNT = 16,
    localparam int WAW       = $clog2(OBJ_COUNT * ENTRY_WORDS)
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           LVBL,
    input  logic           obank,
    input  logic           oram_ok,
    output logic           oram_cs,
    output logic [12:0]    oram_addr,
    output logic           table_we,
    output logic [WAW-1:0] table_waddr
);

    localparam int LAST = OBJ_COUNT * ENTRY_WORDS - 1;

    logic           lvbl_l;
    logic           blank_fall;
    logic           bank;        // bank latched for the whole copy
    logic [WAW-1:0] cnt;

    assign blank_fall  = lvbl_l & ~LVBL;
    assign oram_addr   = {bank, {(12 - WAW){1'b0}}, cnt};
    assign table_we    = oram_cs & oram_ok;    // word arrives this cycle
    assign table_waddr = cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lvbl_l  <= 1'b0;
            oram_cs <= 1'b0;
            bank    <= 1'b0;
            cnt     <= '0;
        end else begin
            lvbl_l <= LVBL;
            if (!oram_cs) begin
                if (blank_fall) begin
                    oram_cs <= 1'b1;
                    bank    <= obank;
                    cnt     <= '0;
                end
            end else if (oram_ok) begin
                if (cnt == WAW'(LAST)) begin
                    oram_cs <= 1'b0;   // table complete
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- src/obj_table_ram.sv
/*
 * sprite table storage
 * one word array per entry field, written by the copier
 * and read combinationally by the scanner; also holds the scroll offsets
 */
`timescale 1ns/1ps

module obj_table_ram import obj_pkg::*; #(
    parameter int  OBJ_COUNT = 16,
    localparam int AW        = $clog2(OBJ_COUNT),
    localparam int WAW       = $clog2(OBJ_COUNT * ENTRY_WORDS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              table_we,
    input  logic [WAW-1:0]    table_waddr,
    input  logic [WORD_W-1:0] oram_data,
    input  logic              objcfg_cs,
    input  logic [2:0]        addr,
    input  logic [WORD_W-1:0] cpu_dout,
    output logic [POS_W-1:0]  off_x,
    output logic [POS_W-1:0]  off_y,
    obj_table_if.ram          tbl
);

    localparam int EW = $clog2(ENTRY_WORDS);

    logic [WORD_W-1:0] mem_x    [OBJ_COUNT];
    logic [WORD_W-1:0] mem_y    [OBJ_COUNT];
    logic [WORD_W-1:0] mem_code [OBJ_COUNT];
    logic [WORD_W-1:0] mem_attr [OBJ_COUNT];
    logic [AW-1:0]     wentry;
    logic [EW-1:0]     wword;

    assign wentry = table_waddr[WAW-1:EW];
    assign wword  = table_waddr[EW-1:0];     // field within the entry

    always_ff @(posedge clk) begin
        if (table_we) begin
            case (wword)
                W_X:     mem_x[wentry]    <= oram_data;
                W_Y:     mem_y[wentry]    <= oram_data;
                W_CODE:  mem_code[wentry] <= oram_data;
                default: mem_attr[wentry] <= oram_data;
            endcase
        end
    end

    assign tbl.x    = mem_x[tbl.addr];
    assign tbl.y    = mem_y[tbl.addr];
    assign tbl.code = mem_code[tbl.addr];
    assign tbl.attr = mem_attr[tbl.addr];

    // scroll registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            off_x <= '0;
            off_y <= '0;
        end else if (objcfg_cs) begin
            case (addr)
                CFG_OFF_X: off_x <= cpu_dout[POS_W-1:0];
                CFG_OFF_Y: off_y <= cpu_dout[POS_W-1:0];
                default:   ;
            endcase
        end
    end

endmodule

//--- src/obj_scan.sv
/*
 * per-line sprite scanner
 * walks the table from the top entry down, finds sprites that cross
 * the line being rendered and hands each one to the drawer
 */
`timescale 1ns/1ps

module obj_scan import obj_pkg::*; #(
    parameter int  OBJ_COUNT = 16,
    localparam int AW        = $clog2(OBJ_COUNT)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [POS_W-1:0] vrender,
    input  logic [POS_W-1:0] off_x,
    input  logic [POS_W-1:0] off_y,
    obj_table_if.scan        tbl,
    obj_draw_if.scan         drw
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_CHECK  = 2'd1;
    localparam logic [1:0] S_LAUNCH = 2'd2;   // strobe out, drawer still idle
    localparam logic [1:0] S_WAIT   = 2'd3;

    logic [1:0]       state;
    logic [AW-1:0]    idx;
    logic [POS_W-1:0] dy;
    logic             hit;
    logic             launch;

    assign tbl.addr = idx;
    assign dy       = vrender + off_y - tbl.y[POS_W-1:0];   // wraps at 512
    assign hit      = ~tbl.attr[ATTR_HIDE] && (dy < POS_W'(OBJ_SIZE));
    assign launch   = (state == S_CHECK) && hit && drw.idle && !start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            idx       <= '0;
            drw.start <= 1'b0;
        end else begin
            drw.start <= 1'b0;
            if (start) begin
                // new line, anything left over is dropped
                idx   <= AW'(OBJ_COUNT - 1);
                state <= S_CHECK;
            end else begin
                case (state)
                    S_CHECK: begin
                        if (hit) begin
                            if (drw.idle) begin
                                drw.start <= 1'b1;
                                state     <= S_LAUNCH;
                            end
                        end else if (idx == '0) begin
                            state <= S_IDLE;
                        end else begin
                            idx <= idx - 1'b1;
                        end
                    end
                    S_LAUNCH: state <= S_WAIT;
                    S_WAIT: begin
                        if (drw.idle) begin
                            if (idx == '0) begin
                                state <= S_IDLE;
                            end else begin
                                idx   <= idx - 1'b1;
                                state <= S_CHECK;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // fields for the drawer, held from the strobe on
    always_ff @(posedge clk) begin
        if (launch) begin
            drw.code  <= tbl.code;
            drw.hpos  <= tbl.x[POS_W-1:0] - off_x;
            drw.row   <= tbl.attr[ATTR_VFLIP] ? ~dy[ROW_W-1:0] : dy[ROW_W-1:0];
            drw.hflip <= tbl.attr[ATTR_HFLIP];
            drw.pal   <= tbl.attr[ATTR_PAL_LSB +: PAL_W];
            drw.prio  <= tbl.attr[ATTR_PRIO_LSB +: PRIO_W];
        end
    end

endmodule

//--- src/obj_draw.sv
/*
 * sprite line drawer
 * fetches the two ROM words of one sprite row and writes the
 * visible pixels into the line buffer, one per cycle
 */
`timescale 1ns/1ps

module obj_draw import obj_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      rom_data,
    input  logic             rom_ok,
    obj_draw_if.draw         drw,
    output logic             rom_cs,
    output logic [19:0]      rom_addr,
    output logic             rom_half,
    output logic [POS_W-1:0] buf_addr,
    output logic [PXL_W-1:0] buf_data,
    output logic             buf_wr
);

    localparam logic [1:0] D_IDLE  = 2'd0;
    localparam logic [1:0] D_FETCH = 2'd1;
    localparam logic [1:0] D_DRAW  = 2'd2;
    localparam logic [1:0] D_LAST  = 2'd3;   // last write in flight

    logic [1:0]        state;
    logic [2:0]        cnt;        // pixel within the current word
    logic [31:0]       pix;
    logic [WORD_W-1:0] code;
    logic [ROW_W-1:0]  row;
    logic [POS_W-1:0]  hpos;
    logic              hflip;
    logic [PAL_W-1:0]  pal;
    logic [PRIO_W-1:0] prio;
    logic [ROW_W-1:0]  col;
    logic [ROW_W-1:0]  ofs;

    assign rom_addr = {code, row};
    assign col      = {rom_half, cnt};         // sprite column
    assign ofs      = hflip ? ~col : col;      // 15 - col when flipped

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= D_IDLE;
            drw.idle <= 1'b1;
            rom_cs   <= 1'b0;
            rom_half <= 1'b0;
            buf_wr   <= 1'b0;
            cnt      <= '0;
        end else begin
            buf_wr <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (drw.start) begin
                        drw.idle <= 1'b0;
                        rom_cs   <= 1'b1;
                        rom_half <= 1'b0;
                        state    <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                        state  <= D_DRAW;
                    end
                end
                D_DRAW: begin
                    buf_wr <= pix[COLOR_W-1:0] != '0;   // color 0 is see-through
                    cnt    <= cnt + 1'b1;
                    if (cnt == 3'd7) begin
                        if (!rom_half) begin
                            rom_half <= 1'b1;
                            rom_cs   <= 1'b1;
                            state    <= D_FETCH;
                        end else begin
                            state <= D_LAST;
                        end
                    end
                end
                default: begin
                    drw.idle <= 1'b1;
                    state    <= D_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_IDLE && drw.start) begin
            code  <= drw.code;
            row   <= drw.row;
            hpos  <= drw.hpos;
            hflip <= drw.hflip;
            pal   <= drw.pal;
            prio  <= drw.prio;
        end
        if (state == D_FETCH && rom_ok) begin
            pix <= rom_data;
        end else if (state == D_DRAW) begin
            pix <= pix >> COLOR_W;    // next pixel into the low nibble
        end
        if (state == D_DRAW) begin
            buf_addr <= hpos + POS_W'(ofs);
            buf_data <= {prio, pal, pix[COLOR_W-1:0]};
        end
    end

endmodule

//--- src/obj_line_buf.sv
/*
 * double-buffered sprite line memory
 * one bank takes drawer writes while the other is streamed out
 * and cleared behind the read; banks swap on every line start
 */
`timescale 1ns/1ps

module obj_line_buf import obj_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  logic             start,
    input  logic [POS_W-1:0] hdump,
    input  logic [POS_W-1:0] buf_addr,
    input  logic [PXL_W-1:0] buf_data,
    input  logic             buf_wr,
    output logic [PXL_W-1:0] pxl
);

    logic [PXL_W-1:0] mem [2**(POS_W+1)];   // {bank, column}
    logic             bank;                 // render bank, display is ~bank
    logic             clr_busy;
    logic [POS_W-1:0] clr_addr;

    // both banks are wiped once after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank     <= 1'b0;
            clr_busy <= 1'b1;
            clr_addr <= '0;
        end else begin
            if (start) begin
                bank <= ~bank;
            end
            if (clr_busy) begin
                clr_addr <= clr_addr + 1'b1;
                clr_busy <= ~&clr_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_busy) begin
            mem[{1'b0, clr_addr}] <= '0;
            mem[{1'b1, clr_addr}] <= '0;
        end else begin
            if (buf_wr) begin
                mem[{bank, buf_addr}] <= buf_data;
            end
            if (pxl_cen) begin
                mem[{~bank, hdump}] <= '0;   // ready for the next render
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= clr_busy ? '0 : mem[{~bank, hdump}];
        end
    end

endmodule

//--- src/obj_engine.sv
/*
 * sprite engine top level
 * copies the sprite table at vertical blank, renders one line ahead
 * into a double line buffer and streams the displayed line out
 */
`timescale 1ns/1ps

module obj_engine import obj_pkg::*; #(
    parameter int OBJ_COUNT = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic              LVBL,
    input  logic              objcfg_cs,
    input  logic [WORD_W-1:0] cpu_dout,
    input  logic [2:0]        addr,
    input  logic              oram_ok,
    input  logic [WORD_W-1:0] oram_data,
    input  logic              obank,
    input  logic              start,
    input  logic [POS_W-1:0]  vrender,   // one line ahead of vdump
    input  logic [POS_W-1:0]  vdump,     // timing generator contract only
    input  logic [POS_W-1:0]  hdump,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output logic              oram_cs,
    output logic [12:0]       oram_addr,
    output logic [19:0]       rom_addr,
    output logic              rom_half,
    output logic              rom_cs,
    output logic [PXL_W-1:0]  pxl
);

    localparam int AW  = $clog2(OBJ_COUNT);
    localparam int WAW = $clog2(OBJ_COUNT * ENTRY_WORDS);

    logic             table_we;
    logic [WAW-1:0]   table_waddr;
    logic [POS_W-1:0] off_x;
    logic [POS_W-1:0] off_y;
    logic [POS_W-1:0] buf_addr;
    logic [PXL_W-1:0] buf_data;
    logic             buf_wr;

    obj_table_if #(.AW(AW)) tbl_if ();
    obj_draw_if drw_if ();

    obj_frame_copy #(.OBJ_COUNT(OBJ_COUNT)) u_copy (
        .clk, .rst_n, .LVBL, .obank, .oram_ok, .oram_cs, .oram_addr,
        .table_we, .table_waddr
    );

    obj_table_ram #(.OBJ_COUNT(OBJ_COUNT)) u_table (
        .clk, .rst_n, .table_we, .table_waddr, .oram_data,
        .objcfg_cs, .addr, .cpu_dout, .off_x, .off_y,
        .tbl (tbl_if.ram)
    );

    obj_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan (
        .clk, .rst_n, .start, .vrender, .off_x, .off_y,
        .tbl (tbl_if.scan),
        .drw (drw_if.scan)
    );

    obj_draw u_draw (
        .clk, .rst_n, .rom_data, .rom_ok,
        .drw (drw_if.draw),
        .rom_cs, .rom_addr, .rom_half, .buf_addr, .buf_data, .buf_wr
    );

    // bank swap shares the line strobe with the scanner
    obj_line_buf u_line (
        .clk, .rst_n, .pxl_cen, .start, .hdump,
        .buf_addr, .buf_data, .buf_wr, .pxl
    );

endmodule

//--- testbench/obj_engine_tb.sv
/*
 * sprite engine testbench
 * drives line and frame timing, models object RAM and graphics ROM
 * and checks every displayed pixel against a line reference model
 */
`timescale 1ns/1ps

module obj_engine_tb import obj_pkg::*; ();

    localparam int OBJ_COUNT   = 8;
    localparam int TBL_WORDS   = OBJ_COUNT * ENTRY_WORDS;
    localparam int LINE_CLK    = 1024;    // 128 pixels at one every 8 clocks
    localparam int LINES       = 24;      // 16 active plus 8 blank
    localparam int FRAMES      = 5;
    localparam int TIMEOUT_CYC = 6 * LINES * LINE_CLK;

    logic              clk;
    logic              rst_n;
    logic              pxl_cen;
    logic              LVBL;
    logic              objcfg_cs;
    logic [WORD_W-1:0] cpu_dout;
    logic [2:0]        addr;
    logic              oram_ok;
    logic [WORD_W-1:0] oram_data;
    logic              obank;
    logic              start;
    logic [POS_W-1:0]  vrender;
    logic [POS_W-1:0]  vdump;
    logic [POS_W-1:0]  hdump;
    logic [31:0]       rom_data;
    logic              rom_ok;
    logic              oram_cs;
    logic [12:0]       oram_addr;
    logic [19:0]       rom_addr;
    logic              rom_half;
    logic              rom_cs;
    logic [PXL_W-1:0]  pxl;

    logic [WORD_W-1:0] oram_mem [0:2*TBL_WORDS-1];   // {bank, word}
    logic [PXL_W-1:0]  next_exp [0:127];
    logic [PXL_W-1:0]  disp_exp [0:127];
    logic              next_ok;
    logic              disp_ok;     // line content is known to the model
    logic              exp_bank;
    logic              tbl_valid;
    int                c, vd, frame;
    int                ox, oy;
    int                oram_cnt, oram_wait, rom_wait, cyc;

    obj_engine #(.OBJ_COUNT(OBJ_COUNT)) i_obj_engine (
        .clk, .rst_n, .pxl_cen, .LVBL, .objcfg_cs, .cpu_dout, .addr,
        .oram_ok, .oram_data, .obank, .start, .vrender, .vdump, .hdump,
        .rom_data, .rom_ok, .oram_cs, .oram_addr, .rom_addr, .rom_half,
        .rom_cs, .pxl
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // graphics ROM contents with bits thinned so plenty of nibbles are zero
    function automatic logic [31:0] rom_word(input logic [19:0] a, input logic half);
        logic [31:0] h;
        h = {11'd0, a, half} * 32'h9e3779b1;
        h = h ^ (h >> 13);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 16);
        return h & {h[26:0], h[31:27]};
    endfunction

    // expected line buffer content for render line r
    task automatic build_line(input int r);
        int          base, dy, row, hp, sc;
        logic [15:0] x, y, code, attr;
        logic [31:0] word;
        logic [3:0]  color;
        for (int i = 0; i < 128; i++) next_exp[i] = '0;
        next_ok = tbl_valid;
        if (!tbl_valid) return;
        for (int e = OBJ_COUNT - 1; e >= 0; e--) begin   // low entries land last
            base = (exp_bank ? TBL_WORDS : 0) + e * ENTRY_WORDS;
            x    = oram_mem[base + W_X];
            y    = oram_mem[base + W_Y];
            code = oram_mem[base + W_CODE];
            attr = oram_mem[base + W_ATTR];
            dy   = (r + oy - int'(y[8:0])) & 511;
            if (!attr[ATTR_HIDE] && dy < OBJ_SIZE) begin
                row = attr[ATTR_VFLIP] ? 15 - dy : dy;
                hp  = (int'(x[8:0]) - ox) & 511;
                for (int col = 0; col < OBJ_SIZE; col++) begin
                    word  = rom_word({code, 4'(row)}, col >= 8);
                    color = word[4*(col%8) +: 4];
                    sc    = (hp + (attr[ATTR_HFLIP] ? 15 - col : col)) & 511;
                    if (color != 0 && sc < 128) begin
                        next_exp[sc] = {attr[ATTR_PRIO_LSB +: PRIO_W],
                                        attr[ATTR_PAL_LSB +: PAL_W], color};
                    end
                end
            end
        end
    endtask

    task automatic check_pixel();
        if (pxl_cen && vd < 16 && disp_ok) begin
            assert (pxl == disp_exp[hdump])
            else report_error($sformatf("line %0d column %0d pxl %h expected %h",
                                        vd, hdump, pxl, disp_exp[hdump]));
        end
    endtask

    task automatic serve_rom();
        rom_ok = 1'b0;
        if (rom_cs) begin
            if (rom_wait < 0) rom_wait = 1 + $urandom % 4;
            rom_wait--;
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr, rom_half);
                rom_wait = -1;
            end
        end
    endtask

    task automatic serve_oram();
        oram_ok = 1'b0;
        if (oram_cs) begin
            if (oram_wait < 0) oram_wait = 1 + $urandom % 3;
            oram_wait--;
            if (oram_wait == 0) begin
                assert (oram_cnt < TBL_WORDS && oram_addr == {exp_bank, 7'd0, 5'(oram_cnt)})
                else report_error($sformatf("ORAM read %0d at address %h",
                                            oram_cnt, oram_addr));
                oram_ok   = 1'b1;
                oram_data = oram_mem[{oram_addr[12], oram_addr[4:0]}];
                oram_cnt++;
                oram_wait = -1;
            end
        end
    endtask

    task automatic write_cfg(input int reg_addr, input int value);
        objcfg_cs = 1'b1;
        addr      = 3'(reg_addr);
        cpu_dout  = 16'(value);
        if (reg_addr == CFG_OFF_X) ox = value;
        else oy = value;
    endtask

    // timing generator with the line start at column 0 ahead of its pixel enable
    task automatic advance();
        c++;
        if (c == LINE_CLK) begin
            c = 0;
            vd++;
            if (vd == LINES) begin
                vd = 0;
                frame++;
            end
        end
        hdump     = POS_W'(c / 8);
        pxl_cen   = (c % 8 == 4);
        start     = (c == 0);
        LVBL      = (vd < 16);
        vdump     = POS_W'(vd);
        vrender   = POS_W'(vd + 1);
        objcfg_cs = 1'b0;
        if (c == 0) begin
            if (vd == 2) obank = frame[0];   // other bank every frame
            if (vd == 16) begin
                exp_bank = obank;
                oram_cnt = 0;
            end
            if (vd == 17) begin
                assert (!oram_cs && oram_cnt == TBL_WORDS)
                else report_error($sformatf("copy ended after %0d words", oram_cnt));
                tbl_valid = 1'b1;
            end
            for (int i = 0; i < 128; i++) disp_exp[i] = next_exp[i];
            disp_ok = next_ok;
            build_line(vd + 1);
        end
        if (vd == 20 && frame == 2) begin
            if (c == 900) write_cfg(CFG_OFF_X, 37);
            if (c == 901) write_cfg(CFG_OFF_Y, 5);
        end
        if (vd == 20 && frame == 3) begin
            if (c == 900) write_cfg(CFG_OFF_X, 500);   // wraps right by 12
            if (c == 901) write_cfg(CFG_OFF_Y, 508);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        check_pixel();
        serve_rom();
        serve_oram();
        advance();
    endtask

    initial begin
        int          seed;
        logic [15:0] attr;
        seed = 32'hcaf;
        void'($urandom(seed));
        for (int a = 0; a < 2 * TBL_WORDS; a++) begin
            case (a % ENTRY_WORDS)
                W_X:     oram_mem[a] = 16'($urandom % 128);
                W_Y:     oram_mem[a] = 16'($urandom % 16);   // visible lines only
                W_CODE:  oram_mem[a] = 16'($urandom);
                default: begin
                    attr = 16'($urandom);
                    attr[ATTR_HIDE] = ($urandom % 4) == 0;
                    oram_mem[a] = attr;
                end
            endcase
        end
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        LVBL      = 1'b1;
        objcfg_cs = 1'b0;
        cpu_dout  = '0;
        addr      = '0;
        oram_ok   = 1'b0;
        oram_data = '0;
        obank     = 1'b0;
        start     = 1'b0;
        vrender   = '0;
        vdump     = '0;
        hdump     = '0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        c         = LINE_CLK - 1;
        vd        = LINES - 1;
        frame     = -1;
        ox        = 0;
        oy        = 0;
        oram_cnt  = 0;
        oram_wait = -1;
        rom_wait  = -1;
        exp_bank  = 1'b0;
        tbl_valid = 1'b0;
        next_ok   = 1'b1;
        disp_ok   = 1'b1;
        for (int i = 0; i < 128; i++) next_exp[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!oram_cs && !rom_cs && pxl == '0)
        else report_error("outputs not idle after reset");
        repeat (FRAMES * LINES * LINE_CLK) step();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        cyc = 0;
        while (cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: run still going after %0d clock cycles", TIMEOUT_CYC);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule

//--- project.f
src/obj_pkg.sv
src/obj_if.sv
src/obj_frame_copy.sv
src/obj_table_ram.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_line_buf.sv
src/obj_engine.sv
testbench/obj_engine_tb.sv
